// File: design/i4_pkg.sv
/*
 * Shared types and constants for the 4x4 intra mode decision:
 * pixel, block, mode, SSE and score types, mode indices,
 * sequencer state bits and the fixed mode cost table
 */

package i4_pkg;

    typedef logic [7:0]        pixel_t;
    // Pixel 0 is top-left, raster order, pixel k at bits [8k+7:8k]
    typedef pixel_t [15:0]     block_t;
    typedef logic [1:0]        mode_t;
    typedef logic [20:0]       sse_t;
    typedef logic [39:0]       score_t;
    typedef logic [15:0]       lambda_t;

    localparam int NUM_MODES   = 4;
    localparam int NUM_SUB     = 16;
    localparam int HEADER_COST = 211;
    localparam int SSE_ROWS    = 4;

    localparam mode_t MODE_DC  = 2'd0;
    localparam mode_t MODE_TM  = 2'd1;
    localparam mode_t MODE_VE  = 2'd2;
    localparam mode_t MODE_HE  = 2'd3;

    // Fixed header cost of each mode, indexed by mode_t
    localparam logic [10:0] MODE_COST [NUM_MODES] = '{11'd40, 11'd1151, 11'd1723, 11'd1874};

    // --------------------------------------------------
    // Sequencer one-hot state bits
    // --------------------------------------------------
    localparam int ST_IDLE     = 0;
    localparam int ST_INIT     = 1;
    localparam int ST_LOAD     = 2;
    localparam int ST_START    = 3;
    localparam int ST_WAIT     = 4;
    localparam int ST_STORE    = 5;
    localparam int ST_UPDATE   = 6;
    localparam int ST_DONE     = 7;
    localparam int NUM_ST      = 8;

endpackage

// File: design/cand_if.sv
/*
 * Candidate bundle of one sub-block: source block, the four
 * predictions, their SSE results and the meter strobes
 */

`timescale 1ns/1ns

interface cand_if;
    import i4_pkg::*;

    logic   start;
    block_t src;
    block_t pred [NUM_MODES];
    sse_t   sse [NUM_MODES];
    logic   done;

    // src and pred held stable from start until done
    modport ctrl (output start, output src, input pred, input done);

    modport predictor (output pred);

    modport meter (input start, input src, input pred, output sse, output done);

    // sse valid from done until the next start
    modport selector (input sse);

endinterface

// File: design/i4_predict.sv
/*
 * DC, TM, VE and HE 4x4 predictors, combinational,
 * built from the top row, left column and top-left pixel
 */

`timescale 1ns/1ns

module i4_predict (
    input  i4_pkg::pixel_t [3:0] top_i,
    input  i4_pkg::pixel_t [3:0] left_i,
    input  i4_pkg::pixel_t       top_left_i,
    cand_if.predictor            cand
);
    import i4_pkg::*;

    block_t      dc_blk;
    block_t      tm_blk;
    block_t      ve_blk;
    block_t      he_blk;
    logic [10:0] dc_sum;
    pixel_t      dc_val;

    // Rounded mean of the eight neighbors
    always_comb begin
        dc_sum = 11'd4;
        for (int k = 0; k < 4; k++) begin
            dc_sum = dc_sum + 11'(top_i[k]) + 11'(left_i[k]);
        end
    end

    assign dc_val = dc_sum[10:3];

    always_comb begin
        logic signed [9:0] tm;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                tm = $signed({2'b00, top_i[x]}) + $signed({2'b00, left_i[y]})
                   - $signed({2'b00, top_left_i});
                // Clip to pixel range
                if (tm < 0) begin
                    tm_blk[4*y+x] = 8'h00;
                end else if (tm > 10'sd255) begin
                    tm_blk[4*y+x] = 8'hff;
                end else begin
                    tm_blk[4*y+x] = tm[7:0];
                end
                dc_blk[4*y+x] = dc_val;
                ve_blk[4*y+x] = top_i[x];
                he_blk[4*y+x] = left_i[y];
            end
        end
    end

    assign cand.pred[MODE_DC] = dc_blk;
    assign cand.pred[MODE_TM] = tm_blk;
    assign cand.pred[MODE_VE] = ve_blk;
    assign cand.pred[MODE_HE] = he_blk;

endmodule

// File: design/i4_sse.sv
/*
 * Row-serial SSE meter, one block row per cycle for all
 * four candidates, done pulse after the last row
 */

`timescale 1ns/1ns

module i4_sse (
    input  logic   clk,
    input  logic   rst_n,
    cand_if.meter  cand
);
    import i4_pkg::*;

    logic        busy_q;
    logic        done_q;
    logic [1:0]  row_q;
    logic [1:0]  row_sel;
    logic [17:0] row_sse [NUM_MODES];
    sse_t        acc_q [NUM_MODES];

    // Row 0 is taken in the start cycle itself
    assign row_sel = cand.start ? 2'd0 : row_q;

    always_comb begin
        logic signed [8:0]  diff;
        logic signed [17:0] sq;
        for (int m = 0; m < NUM_MODES; m++) begin
            row_sse[m] = '0;
            for (int x = 0; x < 4; x++) begin
                diff = $signed({1'b0, cand.src[4*row_sel+x]})
                     - $signed({1'b0, cand.pred[m][4*row_sel+x]});
                sq = diff * diff;
                row_sse[m] = row_sse[m] + $unsigned(sq);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            row_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (cand.start) begin
                busy_q <= 1'b1;
                row_q  <= 2'd1;
            end else if (busy_q) begin
                row_q <= row_q + 2'd1;
                if (row_q == 2'(SSE_ROWS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Start restarts the sums from the first row
    always_ff @(posedge clk) begin
        if (cand.start || busy_q) begin
            for (int m = 0; m < NUM_MODES; m++) begin
                acc_q[m] <= (cand.start ? sse_t'(0) : acc_q[m]) + sse_t'(row_sse[m]);
            end
        end
    end

    assign cand.sse  = acc_q;
    assign cand.done = done_q;

    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        cand.done |-> $past(cand.start, SSE_ROWS))
        else $error("SSE done without a start %0d cycles earlier", SSE_ROWS);

endmodule

// File: design/i4_mode_select.sv
/*
 * Rate-distortion score per mode and choice of the lowest,
 * ties resolved towards the lower mode index
 */

`timescale 1ns/1ns

module i4_mode_select (
    cand_if.selector         cand,
    input  i4_pkg::lambda_t  lambda_i,
    output i4_pkg::mode_t    best_mode_o,
    output i4_pkg::score_t   best_score_o
);
    import i4_pkg::*;

    score_t score [NUM_MODES];

    // 256 x SSE plus lambda times the fixed mode cost
    always_comb begin
        for (int m = 0; m < NUM_MODES; m++) begin
            score[m] = (score_t'(cand.sse[m]) << 8)
                     + score_t'(lambda_i) * score_t'(MODE_COST[m]);
        end
    end

    always_comb begin
        best_mode_o  = MODE_DC;
        best_score_o = score[0];
        for (int m = 1; m < NUM_MODES; m++) begin
            // Strict compare keeps the lower index on a tie
            if (score[m] < best_score_o) begin
                best_mode_o  = mode_t'(m);
                best_score_o = score[m];
            end
        end
    end

endmodule

// File: design/i4_neighbors.sv
/*
 * Neighbor context store: top line of the macroblock, left
 * column and corner pixel, loaded from the borders and
 * rotated with each chosen sub-block
 */

`timescale 1ns/1ns

module i4_neighbors (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  init_i,
    input  i4_pkg::pixel_t [15:0] top_border_i,
    input  i4_pkg::pixel_t [15:0] left_border_i,
    input  i4_pkg::pixel_t        corner_i,
    input  logic                  update_i,
    input  logic [3:0]            sub_idx_i,
    input  i4_pkg::block_t        recon_i,
    output i4_pkg::pixel_t [3:0]  top_o,
    output i4_pkg::pixel_t [3:0]  left_o,
    output i4_pkg::pixel_t        top_left_o
);
    import i4_pkg::*;

    pixel_t [15:0] top_line_q;
    pixel_t [3:0]  left_col_q;
    pixel_t        corner_q;
    logic [4:0]    cur_q;
    logic [1:0]    upd_col;
    logic [1:0]    upd_row;
    logic [1:0]    nxt_row;

    assign upd_col = sub_idx_i[1:0];
    assign upd_row = sub_idx_i[3:2];
    assign nxt_row = upd_row + 2'd1;

    // Index of the sub-block whose context is presented
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_q <= '0;
        end else if (init_i) begin
            cur_q <= '0;
        end else if (update_i) begin
            cur_q <= {1'b0, sub_idx_i} + 5'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (init_i) begin
            top_line_q <= top_border_i;
            left_col_q <= left_border_i[3:0];
            corner_q   <= corner_i;
        end else if (update_i) begin
            for (int k = 0; k < 4; k++) begin
                top_line_q[4*upd_col+k] <= recon_i[12+k];
            end
            if (upd_col == 2'd3) begin
                // Row change, next block sits on the left border
                for (int k = 0; k < 4; k++) begin
                    left_col_q[k] <= left_border_i[4*nxt_row+k];
                end
                corner_q <= left_border_i[4*upd_row+3];
            end else begin
                for (int k = 0; k < 4; k++) begin
                    left_col_q[k] <= recon_i[4*k+3];
                end
                // Old bottom-right of the block above
                corner_q <= top_line_q[4*upd_col+3];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            top_o[k] = top_line_q[4*cur_q[1:0]+k];
        end
    end

    assign left_o     = left_col_q;
    assign top_left_o = corner_q;

    a_update_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        update_i |-> (cur_q < NUM_SUB) && (sub_idx_i == cur_q[3:0]))
        else $error("update for sub-block %0d out of sequence", sub_idx_i);

endmodule

// File: design/i4_ctrl.sv
/*
 * Sub-block sequencer: one-hot FSM over the 16 sub-blocks,
 * source slicing, storage of chosen blocks and modes, and
 * macroblock score accumulation
 */

`timescale 1ns/1ns

module i4_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  i4_pkg::pixel_t [i4_pkg::NUM_SUB*i4_pkg::NUM_SUB-1:0] src_i,
    input  i4_pkg::lambda_t        lambda_i,
    cand_if.ctrl                   cand,
    input  i4_pkg::mode_t          best_mode_i,
    input  i4_pkg::score_t         best_score_i,
    output logic                   init_o,
    output logic                   update_o,
    output logic [3:0]             sub_idx_o,
    output i4_pkg::block_t         recon_o,
    output i4_pkg::pixel_t [i4_pkg::NUM_SUB*i4_pkg::NUM_SUB-1:0] yout_o,
    output i4_pkg::mode_t [i4_pkg::NUM_SUB-1:0] modes_o,
    output i4_pkg::score_t         score_o,
    output logic                   done_o
);
    import i4_pkg::*;

    logic [NUM_ST-1:0]             st_q;
    logic [NUM_ST-1:0]             st_d;
    logic [3:0]                    sub_q;
    logic [1:0]                    row;
    logic [1:0]                    col;
    block_t                        src_blk;
    block_t                        src_q;
    block_t                        sel_blk;
    block_t                        recon_q;
    score_t                        bscore_q;
    score_t                        score_q;
    pixel_t [NUM_SUB*NUM_SUB-1:0]  yout_q;
    mode_t [NUM_SUB-1:0]           modes_q;

    assign row = sub_q[3:2];
    assign col = sub_q[1:0];

    // 4x4 window of the current sub-block
    always_comb begin
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                src_blk[4*y+x] = src_i[NUM_SUB*(4*row+y)+4*col+x];
            end
        end
    end

    assign sel_blk = cand.pred[best_mode_i];

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        st_d = '0;
        unique case (1'b1)
            st_q[ST_IDLE]:   st_d[start_i ? ST_INIT : ST_IDLE] = 1'b1;
            st_q[ST_INIT]:   st_d[ST_LOAD] = 1'b1;
            st_q[ST_LOAD]:   st_d[ST_START] = 1'b1;
            st_q[ST_START]:  st_d[ST_WAIT] = 1'b1;
            st_q[ST_WAIT]:   st_d[cand.done ? ST_STORE : ST_WAIT] = 1'b1;
            st_q[ST_STORE]:  st_d[ST_UPDATE] = 1'b1;
            st_q[ST_UPDATE]: st_d[(sub_q == 4'd15) ? ST_DONE : ST_LOAD] = 1'b1;
            st_q[ST_DONE]:   st_d[ST_IDLE] = 1'b1;
            default:         st_d[ST_IDLE] = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_q    <= NUM_ST'(1) << ST_IDLE;
            sub_q   <= '0;
            score_q <= '0;
            yout_q  <= '0;
            modes_q <= '0;
        end else begin
            st_q <= st_d;
            if (st_q[ST_INIT]) begin
                sub_q   <= '0;
                score_q <= score_t'(lambda_i) * score_t'(HEADER_COST);
            end
            if (st_q[ST_STORE]) begin
                modes_q[sub_q] <= best_mode_i;
                for (int y = 0; y < 4; y++) begin
                    for (int x = 0; x < 4; x++) begin
                        yout_q[NUM_SUB*(4*row+y)+4*col+x] <= sel_blk[4*y+x];
                    end
                end
            end
            if (st_q[ST_UPDATE]) begin
                sub_q   <= sub_q + 4'd1;
                score_q <= score_q + bscore_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st_q[ST_LOAD]) begin
            src_q <= src_blk;
        end
        if (st_q[ST_STORE]) begin
            recon_q  <= sel_blk;
            bscore_q <= best_score_i;
        end
    end

    assign cand.start = st_q[ST_START];
    assign cand.src   = src_q;
    assign init_o     = st_q[ST_INIT];
    assign update_o   = st_q[ST_UPDATE];
    assign sub_idx_o  = sub_q;
    assign recon_o    = recon_q;
    assign yout_o     = yout_q;
    assign modes_o    = modes_q;
    assign score_o    = score_q;
    assign done_o     = st_q[ST_DONE];

    a_done_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        st_q[ST_START] |-> ##SSE_ROWS cand.done)
        else $error("SSE done missing at the end of the wait window");

    a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        cand.done |-> st_q[ST_WAIT])
        else $error("SSE done outside the wait window");

endmodule

// File: design/i4_pick.sv
/*
 * Top level of the 4x4 intra mode decision for one 16x16
 * luma macroblock, plain ports, submodules wired together
 */

`timescale 1ns/1ns

module i4_pick (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  i4_pkg::lambda_t       lambda_i,
    input  logic [2047:0]         src_i,
    input  i4_pkg::pixel_t [15:0] top_i,
    input  i4_pkg::pixel_t [15:0] left_i,
    input  i4_pkg::pixel_t        top_left_i,
    output logic [2047:0]         yout_o,
    output logic [31:0]           modes_o,
    output i4_pkg::score_t        score_o,
    output logic                  done_o
);
    import i4_pkg::*;

    pixel_t [3:0] ctx_top;
    pixel_t [3:0] ctx_left;
    pixel_t       ctx_top_left;
    logic         init;
    logic         update;
    logic [3:0]   sub_idx;
    block_t       recon;
    mode_t        best_mode;
    score_t       best_score;

    cand_if cand ();

    i4_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .src_i        (src_i),
        .lambda_i     (lambda_i),
        .cand         (cand.ctrl),
        .best_mode_i  (best_mode),
        .best_score_i (best_score),
        .init_o       (init),
        .update_o     (update),
        .sub_idx_o    (sub_idx),
        .recon_o      (recon),
        .yout_o       (yout_o),
        .modes_o      (modes_o),
        .score_o      (score_o),
        .done_o       (done_o)
    );

    i4_neighbors i_neighbors (
        .clk           (clk),
        .rst_n         (rst_n),
        .init_i        (init),
        .top_border_i  (top_i),
        .left_border_i (left_i),
        .corner_i      (top_left_i),
        .update_i      (update),
        .sub_idx_i     (sub_idx),
        .recon_i       (recon),
        .top_o         (ctx_top),
        .left_o        (ctx_left),
        .top_left_o    (ctx_top_left)
    );

    i4_predict i_predict (
        .top_i      (ctx_top),
        .left_i     (ctx_left),
        .top_left_i (ctx_top_left),
        .cand       (cand.predictor)
    );

    i4_sse i_sse (
        .clk   (clk),
        .rst_n (rst_n),
        .cand  (cand.meter)
    );

    i4_mode_select i_mode_select (
        .cand         (cand.selector),
        .lambda_i     (lambda_i),
        .best_mode_o  (best_mode),
        .best_score_o (best_score)
    );

endmodule

// File: tb/i4_model.svh
/*
 * Reference model of the 4x4 intra mode decision: neighbor
 * context, DC/TM/VE/HE prediction, SSE, rate-distortion score
 * and a whole macroblock pass over reconstructed blocks
 */

`ifndef I4_MODEL_SVH
`define I4_MODEL_SVH

// Fixed rate cost of each mode
function automatic int model_cost(input int m);
    case (m)
        0:       return 40;
        1:       return 1151;
        2:       return 1723;
        default: return 1874;
    endcase
endfunction

// 4x4 window of sub-block i out of a 16x16 frame
function automatic block_t sub_block(input pixel_t [255:0] f, input int i);
    block_t b;
    for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
            b[4*y+x] = f[16*(4*(i/4)+y) + 4*(i%4) + x];
        end
    end
    return b;
endfunction

function automatic block_t model_predict(input pixel_t [3:0] t, input pixel_t [3:0] l,
                                         input pixel_t c, input int m);
    block_t b;
    int     sum;
    int     v;
    sum = 4;
    for (int k = 0; k < 4; k++) begin
        sum = sum + int'(t[k]) + int'(l[k]);
    end
    for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
            case (m)
                0: b[4*y+x] = pixel_t'(sum / 8);
                1: begin
                    v = int'(t[x]) + int'(l[y]) - int'(c);
                    if (v < 0) begin
                        v = 0;
                    end else if (v > 255) begin
                        v = 255;
                    end
                    b[4*y+x] = pixel_t'(v);
                end
                2:       b[4*y+x] = t[x];
                default: b[4*y+x] = l[y];
            endcase
        end
    end
    return b;
endfunction

function automatic longint model_sse(input block_t a, input block_t b);
    longint s;
    int     d;
    s = 0;
    for (int k = 0; k < 16; k++) begin
        d = int'(a[k]) - int'(b[k]);
        s = s + d * d;
    end
    return s;
endfunction

task automatic model_macroblock(input pixel_t [255:0] src, input pixel_t [15:0] top,
                                input pixel_t [15:0] left, input pixel_t corner,
                                input lambda_t lam, output pixel_t [255:0] rec,
                                output mode_t [15:0] modes, output score_t total);
    pixel_t [3:0] t;
    pixel_t [3:0] l;
    pixel_t       c;
    block_t       p;
    block_t       best_p;
    longint       s;
    longint       best_s;
    longint       sum;
    int           r;
    int           col;
    int           best_m;
    rec = '0;
    modes = '0;
    sum = 211 * longint'(lam);
    for (int i = 0; i < 16; i++) begin
        r = i / 4;
        col = i % 4;
        for (int k = 0; k < 4; k++) begin
            t[k] = (r == 0) ? top[4*col+k] : rec[16*(4*r-1) + 4*col + k];
            l[k] = (col == 0) ? left[4*r+k] : rec[16*(4*r+k) + 4*col - 1];
        end
        if (r == 0 && col == 0) begin
            c = corner;
        end else if (r == 0) begin
            c = top[4*col-1];
        end else if (col == 0) begin
            c = left[4*r-1];
        end else begin
            c = rec[16*(4*r-1) + 4*col - 1];
        end
        // Scan downwards so a tie settles on the lowest index
        best_m = 3;
        best_s = 0;
        best_p = '0;
        for (int m = 3; m >= 0; m--) begin
            p = model_predict(t, l, c, m);
            s = 256 * model_sse(sub_block(src, i), p) + longint'(lam) * model_cost(m);
            if (m == 3 || s <= best_s) begin
                best_s = s;
                best_m = m;
                best_p = p;
            end
        end
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                rec[16*(4*r+y) + 4*col + x] = best_p[4*y+x];
            end
        end
        modes[i] = mode_t'(best_m);
        sum = sum + best_s;
    end
    total = score_t'(sum);
endtask

`endif

// File: tb/tb_i4_pick.sv
/*
 * Testbench for the 4x4 intra mode decision top level:
 * clock and reset, random, flat and striped frames, compare
 * tasks against the reference model, latency and timeout
 */

`timescale 1ns/1ns

module tb_i4_pick;
    import i4_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int N_RANDOM       = 28;
    localparam int N_FLAT         = 2;
    localparam int N_STRIPE       = 4;
    localparam int LATENCY        = 130;
    localparam int FRAME_CYCLES   = 140;
    localparam int MAX_FRAMES     = 40;
    localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES + RESET_CYCLES;

    logic           clk;
    logic           rst_n;
    logic           start;
    lambda_t        lambda;
    pixel_t [255:0] src;
    pixel_t [15:0]  top_border;
    pixel_t [15:0]  left_border;
    pixel_t         corner;
    pixel_t [255:0] yout;
    mode_t [15:0]   modes;
    score_t         score;
    logic           done;

    // Stimulus of the current frame
    pixel_t [255:0] s_src;
    pixel_t [15:0]  s_top;
    pixel_t [15:0]  s_left;
    pixel_t         s_corner;
    lambda_t        s_lambda;
    integer         seed;
    int             cycles;

    `include "i4_model.svh"

    i4_pick i_i4_pick (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start),
        .lambda_i   (lambda),
        .src_i      (src),
        .top_i      (top_border),
        .left_i     (left_border),
        .top_left_i (corner),
        .yout_o     (yout),
        .modes_o    (modes),
        .score_o    (score),
        .done_o     (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        fail_run("Timeout: the run did not finish within its cycle budget");
    end

    // --------------------------------------------------
    // Failure reporting and compare tasks
    // --------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_block(input block_t got, input block_t exp, input int idx);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: sub-block %0d of yout_o is %h, expected %h",
                               $time, idx, got, exp));
        end
    endtask

    task automatic check_mode(input mode_t got, input mode_t exp, input int idx);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: mode of sub-block %0d is %0d, expected %0d",
                               $time, idx, got, exp));
        end
    endtask

    task automatic check_score(input score_t got, input score_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: score_o is %0d, expected %0d",
                               $time, got, exp));
        end
    endtask

    task automatic check_latency(input int got);
        if (got != LATENCY) begin
            fail_run($sformatf("Error at %0t ns: done_o came %0d cycles after start, expected %0d",
                               $time, got, LATENCY));
        end
    endtask

    task automatic check_reset_state();
        if (done !== 1'b0) begin
            fail_run($sformatf("Error at %0t ns: done_o is high after reset", $time));
        end
        for (int i = 0; i < NUM_SUB; i++) begin
            check_block(sub_block(yout, i), '0, i);
            check_mode(modes[i], '0, i);
        end
        check_score(score, '0);
    endtask

    // --------------------------------------------------
    // Frame stimulus
    // --------------------------------------------------
    task automatic make_random(input int f);
        int base;
        base = $random(seed) & 255;
        // Odd frames stay close to one level for tighter contests
        for (int p = 0; p < 256; p++) begin
            s_src[p] = (f % 2) ? pixel_t'(base + ($random(seed) & 15)) : pixel_t'($random(seed));
        end
        for (int k = 0; k < 16; k++) begin
            s_top[k]  = (f % 2) ? pixel_t'(base + ($random(seed) & 15)) : pixel_t'($random(seed));
            s_left[k] = (f % 2) ? pixel_t'(base + ($random(seed) & 15)) : pixel_t'($random(seed));
        end
        s_corner = pixel_t'(base + ($random(seed) & 15));
        if (f % 4 == 3) begin
            s_lambda = (f % 8 == 3) ? 16'h0000 : 16'hffff;
        end else begin
            s_lambda = lambda_t'($random(seed));
        end
    endtask

    task automatic make_flat();
        pixel_t v;
        v = pixel_t'($random(seed));
        s_src = {256{v}};
        s_top = {16{v}};
        s_left = {16{v}};
        s_corner = v;
        s_lambda = lambda_t'($random(seed));
    endtask

    // Vertical stripes copied from the top border, lambda 0
    task automatic make_stripes(input int f);
        for (int x = 0; x < 16; x++) begin
            if (f % 2 == 0 && x % 4 != 0) begin
                s_top[x] = s_top[x-1];
            end else begin
                s_top[x] = pixel_t'($random(seed));
            end
        end
        for (int k = 0; k < 16; k++) begin
            s_left[k] = (f % 2 == 0) ? s_top[0] : pixel_t'($random(seed));
        end
        s_corner = (f % 2 == 0) ? s_top[0] : pixel_t'($random(seed));
        for (int p = 0; p < 256; p++) begin
            s_src[p] = s_top[p % 16];
        end
        s_lambda = '0;
    endtask

    // --------------------------------------------------
    // Frame run and result checks
    // --------------------------------------------------
    task automatic run_frame(input bit second_start, output int n);
        @(posedge clk);
        src <= s_src;
        top_border <= s_top;
        left_border <= s_left;
        corner <= s_corner;
        lambda <= s_lambda;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        n = 0;
        fork
            begin
                do begin
                    @(negedge clk);
                    n++;
                end while (done !== 1'b1 && n < 2 * LATENCY);
            end
            begin
                if (second_start) begin
                    repeat (LATENCY / 2) @(posedge clk);
                    start <= 1'b1;
                    @(posedge clk);
                    start <= 1'b0;
                end
            end
        join
        if (done !== 1'b1) begin
            fail_run("done_o never arrived after start_i was raised");
        end
    endtask

    task automatic run_and_check(input bit second_start);
        int             lat;
        pixel_t [255:0] exp_yout;
        mode_t [15:0]   exp_modes;
        score_t         exp_score;
        run_frame(second_start, lat);
        check_latency(lat);
        model_macroblock(s_src, s_top, s_left, s_corner, s_lambda,
                         exp_yout, exp_modes, exp_score);
        for (int i = 0; i < NUM_SUB; i++) begin
            check_block(sub_block(yout, i), sub_block(exp_yout, i), i);
            check_mode(modes[i], exp_modes[i], i);
        end
        check_score(score, exp_score);
    endtask

    // All SSE zero, so the cheapest mode wins everywhere
    task automatic check_flat();
        for (int i = 0; i < NUM_SUB; i++) begin
            check_mode(modes[i], MODE_DC, i);
        end
        check_score(score, score_t'(s_lambda) * score_t'(211 + 16 * 40));
    endtask

    task automatic watch_no_done(input int n);
        int extra;
        extra = 0;
        repeat (n) begin
            @(negedge clk);
            if (done === 1'b1) begin
                extra++;
            end
        end
        if (extra != 0) begin
            fail_run("done_o pulsed again after a start_i that arrived mid-frame");
        end
    endtask

    initial begin
        seed = 32'hbae74cd5;
        rst_n = 1'b0;
        start = 1'b0;
        lambda = '0;
        src = '0;
        top_border = '0;
        left_border = '0;
        corner = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_state();
        for (int f = 0; f < N_RANDOM; f++) begin
            make_random(f);
            run_and_check(1'b0);
        end
        for (int f = 0; f < N_FLAT; f++) begin
            make_flat();
            run_and_check(1'b0);
            check_flat();
        end
        for (int f = 0; f < N_STRIPE; f++) begin
            make_stripes(f);
            run_and_check(1'b0);
        end
        // Second start in the middle of a frame
        make_random(1);
        run_and_check(1'b1);
        watch_no_done(LATENCY + 10);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tb
design/i4_pkg.sv
design/cand_if.sv
design/i4_predict.sv
design/i4_sse.sv
design/i4_mode_select.sv
design/i4_neighbors.sv
design/i4_ctrl.sv
design/i4_pick.sv
tb/tb_i4_pick.sv

// File: run.sh
#!/bin/sh
# Build and run the i4_pick testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_i4_pick --Mdir obj_dir -o sim_i4_pick -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_i4_pick
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
